// File: compile.f
hw/mem_pkg.sv
hw/cmd_pkg.sv
hw/dp_ram_pipe.sv
hw/mem_arbiter.sv
hw/fill_engine.sv
hw/sum_engine.sv
hw/scratch_top.sv
sim/tb_scratch.sv

// File: hw/cmd_pkg.sv
// Engine command formats
`default_nettype none

package cmd_pkg;

    localparam int CMD_WIDTH = 32;

    localparam logic OP_FILL = 1'b0;
    localparam logic OP_SUM  = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Command layouts, top bit first
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       op;
        logic [6:0] step;  // Added per word.
        logic [7:0] base;
        logic [7:0] count; // Zero means empty.
        logic [7:0] seed;  // Value of the first word.
    } fill_cmd_t;

    typedef struct packed {
        logic       op;
        logic [6:0] reserved;
        logic [7:0] base;
        logic [7:0] count;
        logic [7:0] mask;  // XOR applied to each word.
    } sum_cmd_t;

    // One word, two readings.
    typedef union packed {
        fill_cmd_t fill;
        sum_cmd_t  sum;
    } cmd_word_u;

endpackage : cmd_pkg

`default_nettype wire

// File: hw/dp_ram_pipe.sv
// Pipelined dual-port RAM
`default_nettype none

module dp_ram_pipe (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           en,
    input  wire                           we_a,
    input  wire                           we_b,
    input  wire  [mem_pkg::ADDR_WIDTH-1:0] addr_a,
    input  wire  [mem_pkg::ADDR_WIDTH-1:0] addr_b,
    input  wire  [mem_pkg::DATA_WIDTH-1:0] din_a,
    input  wire  [mem_pkg::DATA_WIDTH-1:0] din_b,
    output logic [mem_pkg::DATA_WIDTH-1:0] dout_a,
    output logic [mem_pkg::DATA_WIDTH-1:0] dout_b
);

    logic                           s1_en, s2_en;
    logic                           s1_we_a, s2_we_a;
    logic                           s1_we_b, s2_we_b;
    logic [mem_pkg::ADDR_WIDTH-1:0] s1_addr_a, s2_addr_a;
    logic [mem_pkg::ADDR_WIDTH-1:0] s1_addr_b, s2_addr_b;
    logic [mem_pkg::DATA_WIDTH-1:0] s1_din_a, s2_din_a;
    logic [mem_pkg::DATA_WIDTH-1:0] s1_din_b, s2_din_b;

    logic [mem_pkg::DATA_WIDTH-1:0] mem [mem_pkg::DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Input stages
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_en     <= 1'b0;
            s1_we_a   <= 1'b0;
            s1_we_b   <= 1'b0;
            s1_addr_a <= '0;
            s1_addr_b <= '0;
            s1_din_a  <= '0;
            s1_din_b  <= '0;
            s2_en     <= 1'b0;
            s2_we_a   <= 1'b0;
            s2_we_b   <= 1'b0;
            s2_addr_a <= '0;
            s2_addr_b <= '0;
            s2_din_a  <= '0;
            s2_din_b  <= '0;
        end else begin
            s1_en     <= en;
            s1_we_a   <= we_a;
            s1_we_b   <= we_b;
            s1_addr_a <= addr_a;
            s1_addr_b <= addr_b;
            s1_din_a  <= din_a;
            s1_din_b  <= din_b;
            s2_en     <= s1_en;
            s2_we_a   <= s1_we_a;
            s2_we_b   <= s1_we_b;
            s2_addr_a <= s1_addr_a;
            s2_addr_b <= s1_addr_b;
            s2_din_a  <= s1_din_a;
            s2_din_b  <= s1_din_b;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Array access, read before write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout_a <= '0;
            dout_b <= '0;
        end else if (s2_en) begin
            if (s2_we_a) mem[s2_addr_a] <= s2_din_a;
            if (s2_we_b) mem[s2_addr_b] <= s2_din_b; // Port B wins a collision.
            dout_a <= mem[s2_addr_a];
            dout_b <= mem[s2_addr_b];
        end
    end

endmodule : dp_ram_pipe

`default_nettype wire

// File: hw/fill_engine.sv
// Arithmetic fill engine
`default_nettype none

module fill_engine (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            cmd_strobe,
    input  wire  [cmd_pkg::CMD_WIDTH-1:0]  cmd_word,
    input  wire                            gnt,
    output logic                           req,
    output logic [mem_pkg::ADDR_WIDTH-1:0] addr,
    output logic [mem_pkg::DATA_WIDTH-1:0] wdata,
    output logic                           busy,
    output logic                           done
);

    cmd_pkg::cmd_word_u             cmd;
    logic                           accept;

    logic [mem_pkg::ADDR_WIDTH-1:0] base_q;
    logic [7:0]                     count_q;
    logic [6:0]                     step_q;
    logic [7:0]                     idx;
    logic [mem_pkg::DATA_WIDTH-1:0] value;  // Seed plus idx times step.

    assign cmd    = cmd_word;
    assign accept = cmd_strobe && (cmd.fill.op == cmd_pkg::OP_FILL) && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            idx  <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                idx  <= '0;
                busy <= (cmd.fill.count != 8'd0);
                done <= (cmd.fill.count == 8'd0); // Empty command.
            end else if (busy && gnt) begin
                idx <= idx + 8'd1;
                if (idx == count_q - 8'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Command fields and the running value.
    always_ff @(posedge clk) begin
        if (accept) begin
            base_q  <= cmd.fill.base;
            count_q <= cmd.fill.count;
            step_q  <= cmd.fill.step;
            value   <= cmd.fill.seed;
        end else if (busy && gnt) begin
            value <= value + {1'b0, step_q};
        end
    end

    assign req   = busy;
    assign addr  = base_q + idx;
    assign wdata = value;

endmodule : fill_engine

`default_nettype wire

// File: hw/mem_arbiter.sv
// Port A round-robin arbiter
`default_nettype none

module mem_arbiter (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            host_en,
    // Fill engine, writes only.
    input  wire                            fill_req,
    input  wire  [mem_pkg::ADDR_WIDTH-1:0] fill_addr,
    input  wire  [mem_pkg::DATA_WIDTH-1:0] fill_wdata,
    output logic                           fill_gnt,
    // Sum engine, reads only.
    input  wire                            sum_req,
    input  wire  [mem_pkg::ADDR_WIDTH-1:0] sum_addr,
    output logic                           sum_gnt,
    output logic                           sum_rd_valid,
    output logic [mem_pkg::DATA_WIDTH-1:0] sum_rd_data,
    // RAM side.
    output logic                           ram_en,
    output logic                           ram_we_a,
    output logic [mem_pkg::ADDR_WIDTH-1:0] ram_addr_a,
    output logic [mem_pkg::DATA_WIDTH-1:0] ram_din_a,
    input  wire  [mem_pkg::DATA_WIDTH-1:0] ram_dout_a
);

    logic                           prio_sum; // Low favors fill.
    logic [mem_pkg::RD_LATENCY-1:0] rd_owner;

    //////////////////////////////////////////////////////////////////////
    // Grant
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        fill_gnt = fill_req && (!sum_req || !prio_sum);
        sum_gnt  = sum_req && (!fill_req || prio_sum);
    end

    // The last winner drops to low priority.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prio_sum <= 1'b0;
        end else if (fill_gnt) begin
            prio_sum <= 1'b1;
        end else if (sum_gnt) begin
            prio_sum <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Port A mux and shared enable
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ram_en     = fill_gnt || sum_gnt || host_en;
        ram_we_a   = fill_gnt;
        ram_addr_a = fill_gnt ? fill_addr : sum_addr;
        ram_din_a  = fill_wdata;
    end

    // Tracks sum reads through the RAM pipeline.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_owner <= '0;
        end else begin
            rd_owner <= {rd_owner[mem_pkg::RD_LATENCY-2:0], sum_gnt};
        end
    end

    assign sum_rd_valid = rd_owner[mem_pkg::RD_LATENCY-1];
    assign sum_rd_data  = ram_dout_a;

endmodule : mem_arbiter

`default_nettype wire

// File: hw/mem_pkg.sv
// Scratchpad memory geometry
`default_nettype none

package mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // Array shape
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH = 8;  // Bits per word.
    localparam int ADDR_WIDTH = 8;
    localparam int DEPTH      = 256; // Words in the array.

    //////////////////////////////////////////////////////////////////////
    // Pipeline and datapath sizes
    //////////////////////////////////////////////////////////////////////

    // Edges from a sampled request to fresh read data at the RAM output.
    localparam int RD_LATENCY = 3;

    localparam int SUM_WIDTH  = 16; // Accumulator, wraps.

endpackage : mem_pkg

`default_nettype wire

// File: hw/scratch_top.sv
// Scratchpad subsystem top
`default_nettype none

module scratch_top (
    input  wire                            clk,
    input  wire                            rst,
    // Host memory port.
    input  wire                            host_en,
    input  wire                            host_we,
    input  wire  [mem_pkg::ADDR_WIDTH-1:0] host_addr,
    input  wire  [mem_pkg::DATA_WIDTH-1:0] host_wdata,
    output logic [mem_pkg::DATA_WIDTH-1:0] host_rdata,
    // Commands.
    input  wire                            cmd_strobe,
    input  wire  [cmd_pkg::CMD_WIDTH-1:0]  cmd_word,
    // Status.
    output logic                           fill_busy,
    output logic                           fill_done,
    output logic                           sum_busy,
    output logic                           sum_done,
    output logic [mem_pkg::SUM_WIDTH-1:0]  sum_result
);

    logic                           fill_req, fill_gnt;
    logic [mem_pkg::ADDR_WIDTH-1:0] fill_addr;
    logic [mem_pkg::DATA_WIDTH-1:0] fill_wdata;
    logic                           sum_req, sum_gnt, sum_rd_valid;
    logic [mem_pkg::ADDR_WIDTH-1:0] sum_addr;
    logic [mem_pkg::DATA_WIDTH-1:0] sum_rd_data;
    logic                           ram_en, ram_we_a;
    logic [mem_pkg::ADDR_WIDTH-1:0] ram_addr_a;
    logic [mem_pkg::DATA_WIDTH-1:0] ram_din_a, ram_dout_a;

    //////////////////////////////////////////////////////////////////////
    // Engines
    //////////////////////////////////////////////////////////////////////

    fill_engine i_fill (
        .clk(clk), .rst(rst), .cmd_strobe(cmd_strobe), .cmd_word(cmd_word),
        .gnt(fill_gnt), .req(fill_req), .addr(fill_addr), .wdata(fill_wdata),
        .busy(fill_busy), .done(fill_done)
    );

    sum_engine i_sum (
        .clk(clk), .rst(rst), .cmd_strobe(cmd_strobe), .cmd_word(cmd_word),
        .gnt(sum_gnt), .rd_valid(sum_rd_valid), .rd_data(sum_rd_data),
        .req(sum_req), .addr(sum_addr), .busy(sum_busy), .done(sum_done),
        .result(sum_result)
    );

    //////////////////////////////////////////////////////////////////////
    // Port A arbitration and the RAM
    //////////////////////////////////////////////////////////////////////

    mem_arbiter i_arb (
        .clk(clk), .rst(rst), .host_en(host_en),
        .fill_req(fill_req), .fill_addr(fill_addr), .fill_wdata(fill_wdata),
        .fill_gnt(fill_gnt),
        .sum_req(sum_req), .sum_addr(sum_addr), .sum_gnt(sum_gnt),
        .sum_rd_valid(sum_rd_valid), .sum_rd_data(sum_rd_data),
        .ram_en(ram_en), .ram_we_a(ram_we_a), .ram_addr_a(ram_addr_a),
        .ram_din_a(ram_din_a), .ram_dout_a(ram_dout_a)
    );

    // Host write only counts with its own enable.
    dp_ram_pipe i_ram (
        .clk(clk), .rst(rst), .en(ram_en),
        .we_a(ram_we_a), .we_b(host_we && host_en),
        .addr_a(ram_addr_a), .addr_b(host_addr),
        .din_a(ram_din_a), .din_b(host_wdata),
        .dout_a(ram_dout_a), .dout_b(host_rdata)
    );

endmodule : scratch_top

`default_nettype wire

// File: hw/sum_engine.sv
// Masked range sum engine
`default_nettype none

module sum_engine (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            cmd_strobe,
    input  wire  [cmd_pkg::CMD_WIDTH-1:0]  cmd_word,
    input  wire                            gnt,
    input  wire                            rd_valid,
    input  wire  [mem_pkg::DATA_WIDTH-1:0] rd_data,
    output logic                           req,
    output logic [mem_pkg::ADDR_WIDTH-1:0] addr,
    output logic                           busy,
    output logic                           done,
    output logic [mem_pkg::SUM_WIDTH-1:0]  result
);

    cmd_pkg::cmd_word_u             cmd;
    logic                           accept;

    logic [mem_pkg::ADDR_WIDTH-1:0] base_q;
    logic [7:0]                     count_q;
    logic [mem_pkg::DATA_WIDTH-1:0] mask_q;
    logic [7:0]                     issued;   // Reads granted.
    logic [7:0]                     returned; // Reads back.
    logic [mem_pkg::SUM_WIDTH-1:0]  acc;
    logic [mem_pkg::SUM_WIDTH-1:0]  word_ext;
    logic [mem_pkg::SUM_WIDTH-1:0]  acc_next;

    assign cmd    = cmd_word;
    assign accept = cmd_strobe && (cmd.sum.op == cmd_pkg::OP_SUM) && !busy;

    assign word_ext = {{(mem_pkg::SUM_WIDTH - mem_pkg::DATA_WIDTH){1'b0}}, rd_data ^ mask_q};
    assign acc_next = acc + word_ext;

    //////////////////////////////////////////////////////////////////////
    // Issue and return tracking
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            issued   <= '0;
            returned <= '0;
            acc      <= '0;
            result   <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                issued   <= '0;
                returned <= '0;
                acc      <= '0;
                result   <= '0;
                busy     <= (cmd.sum.count != 8'd0);
                done     <= (cmd.sum.count == 8'd0);
            end else if (busy) begin
                if (gnt) begin
                    issued <= issued + 8'd1;
                end
                if (rd_valid) begin
                    returned <= returned + 8'd1;
                    acc      <= acc_next;
                    if (returned == count_q - 8'd1) begin // Last word back.
                        busy   <= 1'b0;
                        done   <= 1'b1;
                        result <= acc_next;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            base_q  <= cmd.sum.base;
            count_q <= cmd.sum.count;
            mask_q  <= cmd.sum.mask;
        end
    end

    // Keeps asking until every read of the range is granted.
    assign req  = busy && (issued != count_q);
    assign addr = base_q + issued;

endmodule : sum_engine

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the scratchpad testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_scratch \
    -f compile.f \
    -o sim_scratch

./obj_dir/sim_scratch | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: sim/tb_scratch.sv
// Scratchpad subsystem testbench
`default_nettype none

module tb_scratch;

    localparam int SEED           = 96203;
    localparam int TIMEOUT_CYCLES = 4000; // Roughly four times the full run.

    logic                           clk;
    logic                           rst;
    logic                           host_en;
    logic                           host_we;
    logic [mem_pkg::ADDR_WIDTH-1:0] host_addr;
    logic [mem_pkg::DATA_WIDTH-1:0] host_wdata;
    wire  [mem_pkg::DATA_WIDTH-1:0] host_rdata;
    logic                           cmd_strobe;
    logic [cmd_pkg::CMD_WIDTH-1:0]  cmd_word;
    wire                            fill_busy, fill_done, sum_busy, sum_done;
    wire  [mem_pkg::SUM_WIDTH-1:0]  sum_result;

    logic [7:0] shadow [256]; // Expected memory contents.
    int         cycle_count = 0;

    scratch_top i_dut (
        .clk(clk), .rst(rst), .host_en(host_en), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
        .cmd_strobe(cmd_strobe), .cmd_word(cmd_word),
        .fill_busy(fill_busy), .fill_done(fill_done), .sum_busy(sum_busy),
        .sum_done(sum_done), .sum_result(sum_result)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks and models
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [7:0] base, input int count,
                                              input logic [6:0] step, input logic [7:0] seed);
        cmd_pkg::cmd_word_u w;
        w.fill.op    = cmd_pkg::OP_FILL;
        w.fill.step  = step;
        w.fill.base  = base;
        w.fill.count = 8'(count);
        w.fill.seed  = seed;
        return w;
    endfunction

    function automatic logic [31:0] sum_word(input logic [7:0] base, input int count,
                                             input logic [7:0] mask);
        cmd_pkg::cmd_word_u w;
        w.sum.op       = cmd_pkg::OP_SUM;
        w.sum.reserved = '0;
        w.sum.base     = base;
        w.sum.count    = 8'(count);
        w.sum.mask     = mask;
        return w;
    endfunction

    // Wrapped sum of each word XOR mask.
    function automatic logic [15:0] masked_sum(input logic [7:0] base, input int count,
                                               input logic [7:0] mask);
        logic [15:0] acc;
        acc = '0;
        for (int i = 0; i < count; i++) begin
            acc = acc + 16'(shadow[base + 8'(i)] ^ mask);
        end
        return acc;
    endfunction

    function automatic void apply_fill(input logic [7:0] base, input int count,
                                       input logic [6:0] step, input logic [7:0] seed);
        for (int i = 0; i < count; i++) begin
            shadow[base + 8'(i)] = seed + 8'(i) * {1'b0, step};
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks that start and end on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
        host_en      = 1'b1;
        host_we      = 1'b1;
        host_addr    = addr;
        host_wdata   = data;
        shadow[addr] = data;
        @(negedge clk);
        host_en = 1'b0;
        host_we = 1'b0;
    endtask

    task automatic host_read_check(input logic [7:0] addr);
        host_en   = 1'b1;
        host_we   = 1'b0;
        host_addr = addr;
        @(negedge clk);
        host_en = 1'b0;
        repeat (2) @(negedge clk); // Data lands after the third edge.
        check_value("host_rdata", 16'(shadow[addr]), 16'(host_rdata));
    endtask

    // Range plus two neighbours on each side.
    task automatic check_range(input logic [7:0] base, input int count);
        for (int i = -2; i < count + 2; i++) begin
            host_read_check(base + 8'(i));
        end
    endtask

    task automatic send_cmd(input logic [31:0] word);
        cmd_strobe = 1'b1;
        cmd_word   = word;
        @(negedge clk);
        cmd_strobe = 1'b0;
    endtask

    task automatic wait_fill_done();
        while (!fill_done) begin
            check_value("fill_busy", 16'd1, 16'(fill_busy));
            @(negedge clk);
        end
        check_value("fill_busy", 16'd0, 16'(fill_busy));
    endtask

    task automatic check_idle_state();
        check_value("fill_busy", 16'd0, 16'(fill_busy));
        check_value("fill_done", 16'd0, 16'(fill_done));
        check_value("sum_busy", 16'd0, 16'(sum_busy));
        check_value("sum_done", 16'd0, 16'(sum_done));
        check_value("host_rdata", 16'd0, 16'(host_rdata));
        check_value("sum_result", 16'd0, sum_result);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [7:0]  a, b, d, seed, mask;
        logic [6:0]  step;
        logic [15:0] expected;
        logic [7:0]  addrs [$];
        logic        fill_seen, sum_seen;
        int          n, m;

        clk        = 1'b0;
        rst        = 1'b1;
        host_en    = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        cmd_strobe = 1'b0;
        cmd_word   = '0;
        void'($urandom(SEED));

        @(negedge clk);
        check_idle_state();
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_idle_state();

        for (int i = 0; i < 256; i++) begin
            host_write(8'(i), 8'(i * 37 + 11)); // Known contents everywhere.
        end

        // Host port random writes and readback.
        for (int i = 0; i < 32; i++) begin
            a = 8'($urandom());
            addrs.push_back(a);
            host_write(a, 8'($urandom()));
        end
        foreach (addrs[i]) begin
            host_read_check(addrs[i]);
        end

        // Write and read in one access.
        a          = 8'($urandom());
        d          = ~shadow[a];
        host_en    = 1'b1;
        host_we    = 1'b1;
        host_addr  = a;
        host_wdata = d;
        @(negedge clk);
        host_en = 1'b0;
        host_we = 1'b0;
        repeat (2) @(negedge clk);
        check_value("host_rdata", 16'(shadow[a]), 16'(host_rdata));
        shadow[a] = d;
        host_read_check(a);

        // Fill.
        a    = 8'($urandom());
        n    = 8 + int'($urandom() % 40);
        step = 7'($urandom());
        seed = 8'($urandom());
        send_cmd(fill_word(a, n, step, seed));
        wait_fill_done();
        apply_fill(a, n, step, seed);
        repeat (3) @(negedge clk);
        check_range(a, n);

        // Sum followed by an empty sum.
        a        = 8'($urandom());
        n        = 16 + int'($urandom() % 48);
        mask     = 8'($urandom());
        expected = masked_sum(a, n, mask);
        send_cmd(sum_word(a, n, mask));
        while (!sum_done) begin
            check_value("sum_busy", 16'd1, 16'(sum_busy));
            @(negedge clk);
        end
        check_value("sum_result", expected, sum_result);
        check_value("sum_busy", 16'd0, 16'(sum_busy));
        send_cmd(sum_word(8'($urandom()), 0, 8'($urandom())));
        check_value("sum_done", 16'd1, 16'(sum_done));
        check_value("sum_result", 16'd0, sum_result);

        // Both engines on disjoint ranges.
        a        = 8'($urandom());
        n        = 24 + int'($urandom() % 16);
        step     = 7'($urandom());
        seed     = 8'($urandom());
        b        = a + 8'd128;
        m        = 24 + int'($urandom() % 16);
        mask     = 8'($urandom());
        expected = masked_sum(b, m, mask);
        send_cmd(fill_word(a, n, step, seed));
        send_cmd(sum_word(b, m, mask));
        fill_seen = 1'b0;
        sum_seen  = 1'b0;
        while (!(fill_seen && sum_seen)) begin
            if (fill_done) begin
                fill_seen = 1'b1;
            end
            if (sum_done) begin
                sum_seen = 1'b1;
                check_value("sum_result", expected, sum_result);
            end
            @(negedge clk);
        end
        apply_fill(a, n, step, seed);
        repeat (3) @(negedge clk);
        check_range(a, n);

        // Fill command while busy is dropped.
        a    = 8'($urandom());
        n    = 16 + int'($urandom() % 16);
        step = 7'($urandom());
        seed = 8'($urandom());
        send_cmd(fill_word(a, n, step, seed));
        repeat (3) @(negedge clk);
        check_value("fill_busy", 16'd1, 16'(fill_busy));
        b = a + 8'd100;
        send_cmd(fill_word(b, 16, ~step, ~seed));
        wait_fill_done();
        apply_fill(a, n, step, seed);
        repeat (3) @(negedge clk);
        check_value("fill_busy", 16'd0, 16'(fill_busy));
        check_range(a, n);
        check_range(b, 16);

        $display("Test OK");
        $finish;
    end

endmodule : tb_scratch

`default_nettype wire
